//--- Makefile
TOP := tb_dram_traffic_top
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		-f dram_traffic_top.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then exit 1; fi
	@grep -q "Everything OK" $(LOG)

lint:
	verilator --lint-only --timing --assert -f dram_traffic_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- dram_traffic_top.f
hdl/dram_traffic_pkg.sv
hdl/traffic_scheduler.sv
hdl/sample_write_channel.sv
hdl/audio_read_channel.sv
hdl/video_read_channel.sv
hdl/read_response_router.sv
hdl/dram_traffic_top.sv
verif/dram_model.sv
verif/tb_dram_traffic_top.sv

//--- hdl/audio_read_channel.sv
`timescale 1ns/1ns

module audio_read_channel import dram_traffic_pkg::*; (
    input  logic  clk_dram_ctrl,
    input  logic  rst_dram_ctrl,
    input  logic  i_aud_addr_valid,
    input  addr_t i_aud_addr,
    input  logic  i_load_complete,
    input  logic  i_grant,
    output logic  o_aud_addr_ready,
    output logic  o_req,
    output addr_t o_addr
);

    logic  full;
    addr_t held_addr;
    logic  xfer;

    // audio waits until samples are loaded
    assign o_aud_addr_ready = !full && i_load_complete;
    assign xfer             = i_aud_addr_valid && o_aud_addr_ready;

    assign o_req  = full;
    assign o_addr = held_addr;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            full <= 1'b0;
        end else if (xfer) begin
            full <= 1'b1;
        end else if (i_grant) begin
            full <= 1'b0;
        end
    end

    // address payload
    always_ff @(posedge clk_dram_ctrl) begin
        if (xfer) begin
            held_addr <= i_aud_addr;
        end
    end

endmodule

//--- hdl/dram_traffic_pkg.sv
package dram_traffic_pkg;

    // memory word and address sizes
    localparam int ADDR_W = 24;
    localparam int DATA_W = 128;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // requests in flight, bounded by the tag fifo
    localparam int TAG_FIFO_DEPTH = 8;
    localparam int TAG_PTR_W      = $clog2(TAG_FIFO_DEPTH);

    // frame region, 1280x720 at 16 bits per pixel, 8 pixels per word
    localparam addr_t VIDEO_BASE_ADDR   = 24'h100000;
    localparam int    VIDEO_FRAME_WORDS = 115200;
    localparam addr_t VIDEO_LAST_ADDR   = VIDEO_BASE_ADDR + addr_t'(VIDEO_FRAME_WORDS - 1);

    // scheduler phases
    typedef enum logic [1:0] {
        SCHED_LOAD,
        SCHED_DRAIN,
        SCHED_RUN
    } sched_state_t;

    // request source, doubles as the tag stored per request
    typedef enum logic [1:0] {
        SRC_WRITE,
        SRC_AUDIO,
        SRC_VIDEO
    } req_src_t;

endpackage

//--- hdl/dram_traffic_top.sv
`timescale 1ns/1ns

module dram_traffic_top import dram_traffic_pkg::*; (
    input  logic  clk_dram_ctrl,
    input  logic  rst_dram_ctrl,

    // sample load stream
    input  logic  i_wr_valid,
    input  data_t i_wr_data,
    input  logic  i_wr_last,
    output logic  o_wr_ready,

    // audio address stream
    input  logic  i_aud_addr_valid,
    input  addr_t i_aud_addr,
    output logic  o_aud_addr_ready,

    // audio return strobe
    output logic  o_aud_rd_valid,
    output addr_t o_aud_rd_addr,
    output data_t o_aud_rd_data,

    // video reader
    input  logic  i_video_af,
    output logic  o_video_rd_valid,
    output data_t o_video_rd_data,

    // pipelined memory port
    output logic  o_mem_stb,
    output logic  o_mem_we,
    output addr_t o_mem_addr,
    output data_t o_mem_wdata,
    input  logic  i_mem_stall,
    input  logic  i_mem_ack,
    input  data_t i_mem_rdata,

    output logic  o_sample_load_complete
);

    // channel requests toward the scheduler
    logic     wr_req;
    addr_t    wr_addr;
    data_t    wr_data;
    logic     wr_is_last;
    logic     aud_req;
    addr_t    aud_addr;
    logic     vid_req;
    addr_t    vid_addr;

    // one-hot grants back to the channels
    logic     wr_grant;
    logic     aud_grant;
    logic     vid_grant;

    // tag fifo push and status
    logic     push;
    req_src_t push_src;
    addr_t    push_addr;
    logic     fifo_full;
    logic     fifo_empty;

    logic     load_complete;

    assign o_sample_load_complete = load_complete;

    traffic_scheduler u_scheduler (
        .clk_dram_ctrl          (clk_dram_ctrl),
        .rst_dram_ctrl          (rst_dram_ctrl),
        .i_wr_req               (wr_req),
        .i_wr_addr              (wr_addr),
        .i_wr_data              (wr_data),
        .i_wr_is_last           (wr_is_last),
        .i_aud_req              (aud_req),
        .i_aud_addr             (aud_addr),
        .i_vid_req              (vid_req),
        .i_vid_addr             (vid_addr),
        .i_fifo_full            (fifo_full),
        .i_fifo_empty           (fifo_empty),
        .i_mem_stall            (i_mem_stall),
        .o_wr_grant             (wr_grant),
        .o_aud_grant            (aud_grant),
        .o_vid_grant            (vid_grant),
        .o_push                 (push),
        .o_push_src             (push_src),
        .o_push_addr            (push_addr),
        .o_mem_stb              (o_mem_stb),
        .o_mem_we               (o_mem_we),
        .o_mem_addr             (o_mem_addr),
        .o_mem_wdata            (o_mem_wdata),
        .o_sample_load_complete (load_complete)
    );

    sample_write_channel u_write_channel (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_wr_valid    (i_wr_valid),
        .i_wr_data     (i_wr_data),
        .i_wr_last     (i_wr_last),
        .i_grant       (wr_grant),
        .o_wr_ready    (o_wr_ready),
        .o_req         (wr_req),
        .o_addr        (wr_addr),
        .o_data        (wr_data),
        .o_is_last     (wr_is_last)
    );

    audio_read_channel u_audio_channel (
        .clk_dram_ctrl    (clk_dram_ctrl),
        .rst_dram_ctrl    (rst_dram_ctrl),
        .i_aud_addr_valid (i_aud_addr_valid),
        .i_aud_addr       (i_aud_addr),
        .i_load_complete  (load_complete),
        .i_grant          (aud_grant),
        .o_aud_addr_ready (o_aud_addr_ready),
        .o_req            (aud_req),
        .o_addr           (aud_addr)
    );

    video_read_channel u_video_channel (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_enable      (load_complete),
        .i_video_af    (i_video_af),
        .i_grant       (vid_grant),
        .o_req         (vid_req),
        .o_addr        (vid_addr)
    );

    read_response_router u_router (
        .clk_dram_ctrl    (clk_dram_ctrl),
        .rst_dram_ctrl    (rst_dram_ctrl),
        .i_push           (push),
        .i_push_src       (push_src),
        .i_push_addr      (push_addr),
        .i_mem_ack        (i_mem_ack),
        .i_mem_rdata      (i_mem_rdata),
        .o_full           (fifo_full),
        .o_empty          (fifo_empty),
        .o_aud_rd_valid   (o_aud_rd_valid),
        .o_aud_rd_addr    (o_aud_rd_addr),
        .o_aud_rd_data    (o_aud_rd_data),
        .o_video_rd_valid (o_video_rd_valid),
        .o_video_rd_data  (o_video_rd_data)
    );

endmodule

//--- hdl/read_response_router.sv
`timescale 1ns/1ns

module read_response_router import dram_traffic_pkg::*; (
    input  logic     clk_dram_ctrl,
    input  logic     rst_dram_ctrl,
    input  logic     i_push,
    input  req_src_t i_push_src,
    input  addr_t    i_push_addr,
    input  logic     i_mem_ack,
    input  data_t    i_mem_rdata,
    output logic     o_full,
    output logic     o_empty,
    output logic     o_aud_rd_valid,
    output addr_t    o_aud_rd_addr,
    output data_t    o_aud_rd_data,
    output logic     o_video_rd_valid,
    output data_t    o_video_rd_data
);

    // tag storage, one entry per request in flight
    req_src_t             src_mem  [TAG_FIFO_DEPTH];
    addr_t                addr_mem [TAG_FIFO_DEPTH];
    logic [TAG_PTR_W-1:0] wr_ptr;
    logic [TAG_PTR_W-1:0] rd_ptr;
    logic [TAG_PTR_W:0]   count;

    req_src_t head_src;
    addr_t    head_addr;
    logic     aud_valid;
    logic     vid_valid;
    addr_t    aud_addr_q;
    data_t    rdata_q;

    assign o_full  = (count == (TAG_PTR_W+1)'(TAG_FIFO_DEPTH));
    assign o_empty = (count == '0);

    assign head_src  = src_mem[rd_ptr];
    assign head_addr = addr_mem[rd_ptr];

    // pointers and occupancy, push and pop may coincide
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_mem_ack) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_push, i_mem_ack})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (i_push) begin
            src_mem[wr_ptr]  <= i_push_src;
            addr_mem[wr_ptr] <= i_push_addr;
        end
    end

    // return strobes, write acks are dropped here
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            aud_valid <= 1'b0;
            vid_valid <= 1'b0;
        end else begin
            aud_valid <= i_mem_ack && (head_src == SRC_AUDIO);
            vid_valid <= i_mem_ack && (head_src == SRC_VIDEO);
        end
    end

    // read data and its address
    always_ff @(posedge clk_dram_ctrl) begin
        if (i_mem_ack) begin
            rdata_q    <= i_mem_rdata;
            aud_addr_q <= head_addr;
        end
    end

    assign o_aud_rd_valid   = aud_valid;
    assign o_aud_rd_addr    = aud_addr_q;
    assign o_aud_rd_data    = rdata_q;
    assign o_video_rd_valid = vid_valid;
    assign o_video_rd_data  = rdata_q;

endmodule

//--- hdl/sample_write_channel.sv
`timescale 1ns/1ns

module sample_write_channel import dram_traffic_pkg::*; (
    input  logic  clk_dram_ctrl,
    input  logic  rst_dram_ctrl,
    input  logic  i_wr_valid,
    input  data_t i_wr_data,
    input  logic  i_wr_last,
    input  logic  i_grant,
    output logic  o_wr_ready,
    output logic  o_req,
    output addr_t o_addr,
    output data_t o_data,
    output logic  o_is_last
);

    logic  full;
    logic  last_seen;
    logic  held_last;
    data_t held_data;
    addr_t wr_addr;
    logic  xfer;

    // no more words once the last one is in
    assign o_wr_ready = !full && !last_seen;
    assign xfer       = i_wr_valid && o_wr_ready;

    assign o_req     = full;
    assign o_addr    = wr_addr;
    assign o_data    = held_data;
    assign o_is_last = held_last;

    // control flags and the word address
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            full      <= 1'b0;
            last_seen <= 1'b0;
            wr_addr   <= '0;
        end else begin
            if (xfer) begin
                full <= 1'b1;
                if (i_wr_last) begin
                    last_seen <= 1'b1;
                end
            end else if (i_grant) begin
                full    <= 1'b0;
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    // holding register payload
    always_ff @(posedge clk_dram_ctrl) begin
        if (xfer) begin
            held_data <= i_wr_data;
            held_last <= i_wr_last;
        end
    end

endmodule

//--- hdl/traffic_scheduler.sv
`timescale 1ns/1ns

module traffic_scheduler import dram_traffic_pkg::*; (
    input  logic     clk_dram_ctrl,
    input  logic     rst_dram_ctrl,
    input  logic     i_wr_req,
    input  addr_t    i_wr_addr,
    input  data_t    i_wr_data,
    input  logic     i_wr_is_last,
    input  logic     i_aud_req,
    input  addr_t    i_aud_addr,
    input  logic     i_vid_req,
    input  addr_t    i_vid_addr,
    input  logic     i_fifo_full,
    input  logic     i_fifo_empty,
    input  logic     i_mem_stall,
    output logic     o_wr_grant,
    output logic     o_aud_grant,
    output logic     o_vid_grant,
    output logic     o_push,
    output req_src_t o_push_src,
    output addr_t    o_push_addr,
    output logic     o_mem_stb,
    output logic     o_mem_we,
    output addr_t    o_mem_addr,
    output data_t    o_mem_wdata,
    output logic     o_sample_load_complete
);

    sched_state_t state;
    req_src_t     sel_src;
    logic         sel_valid;
    addr_t        sel_addr;
    logic         grant;

    // a stalled strobe keeps its source until accepted
    logic         held_valid;
    req_src_t     held_src;

    // pick the source for this cycle
    always_comb begin
        sel_valid = 1'b0;
        sel_src   = SRC_WRITE;
        if (held_valid) begin
            sel_valid = 1'b1;
            sel_src   = held_src;
        end else if (!i_fifo_full) begin
            case (state)
                SCHED_LOAD: begin
                    sel_valid = i_wr_req;
                    sel_src   = SRC_WRITE;
                end
                SCHED_RUN: begin
                    // audio wins over video
                    if (i_aud_req) begin
                        sel_valid = 1'b1;
                        sel_src   = SRC_AUDIO;
                    end else if (i_vid_req) begin
                        sel_valid = 1'b1;
                        sel_src   = SRC_VIDEO;
                    end
                end
                default: begin
                    // drain issues nothing
                    sel_valid = 1'b0;
                end
            endcase
        end
    end

    always_comb begin
        case (sel_src)
            SRC_WRITE: sel_addr = i_wr_addr;
            SRC_AUDIO: sel_addr = i_aud_addr;
            default:   sel_addr = i_vid_addr;
        endcase
    end

    // accepted when not stalled
    assign grant       = sel_valid && !i_mem_stall;
    assign o_wr_grant  = grant && (sel_src == SRC_WRITE);
    assign o_aud_grant = grant && (sel_src == SRC_AUDIO);
    assign o_vid_grant = grant && (sel_src == SRC_VIDEO);

    // memory port
    assign o_mem_stb   = sel_valid;
    assign o_mem_we    = (sel_src == SRC_WRITE);
    assign o_mem_addr  = sel_addr;
    assign o_mem_wdata = i_wr_data;

    // tag push on every accepted request
    assign o_push      = grant;
    assign o_push_src  = sel_src;
    assign o_push_addr = sel_addr;

    // complete as soon as the last write ack has left the fifo
    assign o_sample_load_complete = (state == SCHED_RUN) ||
                                    ((state == SCHED_DRAIN) && i_fifo_empty);

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            state      <= SCHED_LOAD;
            held_valid <= 1'b0;
            held_src   <= SRC_WRITE;
        end else begin
            held_valid <= sel_valid && i_mem_stall;
            held_src   <= sel_src;
            case (state)
                SCHED_LOAD: begin
                    if (o_wr_grant && i_wr_is_last) begin
                        state <= SCHED_DRAIN;
                    end
                end
                SCHED_DRAIN: begin
                    if (i_fifo_empty) begin
                        state <= SCHED_RUN;
                    end
                end
                default: begin
                    state <= SCHED_RUN;
                end
            endcase
        end
    end

endmodule

//--- hdl/video_read_channel.sv
`timescale 1ns/1ns

module video_read_channel import dram_traffic_pkg::*; (
    input  logic  clk_dram_ctrl,
    input  logic  rst_dram_ctrl,
    input  logic  i_enable,
    input  logic  i_video_af,
    input  logic  i_grant,
    output logic  o_req,
    output addr_t o_addr
);

    addr_t rd_addr;
    logic  frame_end;

    // held back while the downstream buffer is almost full
    assign o_req  = i_enable && !i_video_af;
    assign o_addr = rd_addr;

    // last word of the frame region
    assign frame_end = (rd_addr == VIDEO_LAST_ADDR);

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            rd_addr <= VIDEO_BASE_ADDR;
        end else if (i_grant) begin
            // loop back to the frame start
            if (frame_end) begin
                rd_addr <= VIDEO_BASE_ADDR;
            end else begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

endmodule

//--- verif/dram_model.sv
`timescale 1ns/1ns

module dram_model import dram_traffic_pkg::*; #(
    parameter logic [31:0] SEED = 32'd98
) (
    input  logic  clk_dram_ctrl,
    input  logic  rst_dram_ctrl,
    input  logic  i_stb,
    input  logic  i_we,
    input  addr_t i_addr,
    input  data_t i_wdata,
    output logic  o_stall,
    output logic  o_ack,
    output data_t o_rdata
);

    data_t       mem [addr_t];
    logic [31:0] lcg_state = SEED;
    logic [2:0]  pipe_v = '0;
    data_t       pipe_d [3];

    // never written words read back as the address repeated
    function automatic data_t stored_word(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return data_t'({6{a}});
    endfunction

    // 32 bit lcg behind the stall pattern
    function automatic logic [31:0] advance_rand(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    initial begin
        o_stall = 1'b0;
        o_ack   = 1'b0;
        o_rdata = '0;
    end

    // accepted requests walk a three stage pipe
    always @(posedge clk_dram_ctrl) begin
        if (i_stb && !o_stall && i_we) begin
            mem[i_addr] = i_wdata;
        end
        pipe_v    <= {pipe_v[1:0], i_stb && !o_stall && !rst_dram_ctrl};
        pipe_d[0] <= stored_word(i_addr);
        pipe_d[1] <= pipe_d[0];
        pipe_d[2] <= pipe_d[1];
    end

    // stall about one cycle in four
    always @(negedge clk_dram_ctrl) begin
        lcg_state = advance_rand(lcg_state);
        o_stall   <= (lcg_state[17:16] == 2'b00);
        o_ack     <= pipe_v[2];
        o_rdata   <= pipe_d[2];
    end

endmodule

//--- verif/tb_dram_traffic_top.sv
`timescale 1ns/1ns

module tb_dram_traffic_top import dram_traffic_pkg::*; ();

    localparam int          LOAD_WORDS  = 16;
    localparam int          ACK_LATENCY = 3;
    localparam logic [31:0] SEED        = 32'd98;
    localparam int          MAX_CYCLES  = 4000;

    logic  clk_dram_ctrl;
    logic  rst_dram_ctrl;
    logic  i_wr_valid, i_wr_last, o_wr_ready;
    data_t i_wr_data;
    logic  i_aud_addr_valid, o_aud_addr_ready;
    addr_t i_aud_addr;
    logic  o_aud_rd_valid;
    addr_t o_aud_rd_addr;
    data_t o_aud_rd_data;
    logic  i_video_af, o_video_rd_valid;
    data_t o_video_rd_data;
    logic  o_mem_stb, o_mem_we, i_mem_stall, i_mem_ack;
    addr_t o_mem_addr;
    data_t o_mem_wdata, i_mem_rdata;
    logic  o_sample_load_complete;

    // scoreboard state
    int          errors = 0;
    int          cycles = 0;
    logic [31:0] lcg = SEED;
    data_t       load_data [LOAD_WORDS];
    data_t       wr_q [$];
    addr_t       aud_q [$];
    data_t       wr_head;
    addr_t       aud_head;
    addr_t       vid_head = VIDEO_BASE_ADDR;
    int          wr_count = 0;
    int          wr_acks = 0;
    int          aud_returned = 0;
    int          vid_returned = 0;
    int          inflight = 0;
    int          vid_inflight = 0;
    logic        after_reset = 1'b0;
    logic        last_taken = 1'b0;
    logic        one_after_ack = 1'b0;
    logic        complete_seen = 1'b0;
    logic        prev_stall = 1'b0;
    logic        mem_accept;

    // audio address taken by the stream and not yet strobed to memory
    logic        aud_pending = 1'b0;
    addr_t       aud_last;

    // stb, aud_rd_valid, video_rd_valid, load_complete, aud_addr_ready, wr_ready
    logic [5:0]  reset_outs;

    assign mem_accept = o_mem_stb && !i_mem_stall;
    assign reset_outs = {o_mem_stb, o_aud_rd_valid, o_video_rd_valid,
                         o_sample_load_complete, o_aud_addr_ready, o_wr_ready};

    dram_traffic_top DUT (.*);

    dram_model #(.SEED(SEED)) u_mem (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_stb         (o_mem_stb),
        .i_we          (o_mem_we),
        .i_addr        (o_mem_addr),
        .i_wdata       (o_mem_wdata),
        .o_stall       (i_mem_stall),
        .o_ack         (i_mem_ack),
        .o_rdata       (i_mem_rdata)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic data_t unwritten_word(input addr_t a);
        return data_t'({6{a}});
    endfunction

    initial begin
        clk_dram_ctrl = 1'b0;
        forever #10 clk_dram_ctrl = ~clk_dram_ctrl;
    end

    // bookkeeping updated after the checks sample each edge
    always @(posedge clk_dram_ctrl) begin
        cycles <= cycles + 1;
        if (!rst_dram_ctrl) begin
            if (i_wr_valid && o_wr_ready) begin
                wr_q.push_back(i_wr_data);
                if (i_wr_last) last_taken <= 1'b1;
            end
            if (mem_accept && o_mem_we) begin
                void'(wr_q.pop_front());
                wr_count <= wr_count + 1;
            end
            wr_head <= (wr_q.size() > 0) ? wr_q[0] : '0;
            if (o_aud_rd_valid) begin
                void'(aud_q.pop_front());
                aud_returned <= aud_returned + 1;
            end
            // audio reads sit below the frame region
            if (mem_accept && !o_mem_we && o_mem_addr < VIDEO_BASE_ADDR) aud_pending <= 1'b0;
            if (i_aud_addr_valid && o_aud_addr_ready) begin
                aud_q.push_back(i_aud_addr);
                aud_pending <= 1'b1;
                aud_last    <= i_aud_addr;
            end
            aud_head <= (aud_q.size() > 0) ? aud_q[0] : '0;
            if (o_video_rd_valid) begin
                vid_head     <= vid_head + 1'b1;
                vid_returned <= vid_returned + 1;
            end
            // all acks before completion belong to writes
            one_after_ack <= i_mem_ack && (wr_acks == LOAD_WORDS - 1);
            if (i_mem_ack && wr_acks < LOAD_WORDS) wr_acks <= wr_acks + 1;
            if (o_sample_load_complete) complete_seen <= 1'b1;
            inflight <= inflight + int'(mem_accept) - int'(i_mem_ack);
            vid_inflight <= vid_inflight
                + int'(mem_accept && !o_mem_we && o_mem_addr >= VIDEO_BASE_ADDR)
                - int'(o_video_rd_valid);
            prev_stall <= o_mem_stb && i_mem_stall;
        end
    end

    // run limit
    always @(posedge clk_dram_ctrl) begin
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped, no finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // reset values
    a_reset: assert property (@(posedge clk_dram_ctrl) after_reset |->
        (reset_outs == 6'b000001))
        else begin
            $display("CHECK FAILED reset_outs expected %h got %h",
                6'b000001, $sampled(reset_outs));
            errors++;
        end

    // write stream reaches memory in order
    a_wr_addr: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (mem_accept && o_mem_we) |-> (o_mem_addr == addr_t'(wr_count)))
        else begin
            $display("CHECK FAILED o_mem_addr expected %h got %h",
                addr_t'($sampled(wr_count)), $sampled(o_mem_addr));
            errors++;
        end

    a_wr_data: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (mem_accept && o_mem_we) |-> (o_mem_wdata == wr_head))
        else begin
            $display("CHECK FAILED o_mem_wdata expected %h got %h",
                $sampled(wr_head), $sampled(o_mem_wdata));
            errors++;
        end

    a_no_read_in_load: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        !o_sample_load_complete |-> !(o_mem_stb && !o_mem_we))
        else begin
            $display("read strobe issued before the load completed");
            errors++;
        end

    a_ready_after_last: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        last_taken |-> !o_wr_ready)
        else begin
            $display("write stream ready again after the last word");
            errors++;
        end

    // completion one cycle after the sixteenth ack and never earlier
    a_complete_rise: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (!complete_seen && !one_after_ack) |-> !o_sample_load_complete)
        else begin
            $display("load complete rose at the wrong cycle");
            errors++;
        end

    a_complete_on: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (one_after_ack || complete_seen) |-> o_sample_load_complete)
        else begin
            $display("load complete missing or dropped");
            errors++;
        end

    a_aud_ready: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (complete_seen && !aud_pending) |-> o_aud_addr_ready)
        else begin
            $display("audio address stream not ready after completion");
            errors++;
        end

    // audio return carries address and loaded data
    a_aud_addr: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        o_aud_rd_valid |-> (o_aud_rd_addr == aud_head))
        else begin
            $display("CHECK FAILED o_aud_rd_addr expected %h got %h",
                $sampled(aud_head), $sampled(o_aud_rd_addr));
            errors++;
        end

    a_aud_data: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        o_aud_rd_valid |-> (o_aud_rd_data == load_data[aud_head[3:0]]))
        else begin
            $display("CHECK FAILED o_aud_rd_data expected %h got %h",
                load_data[$sampled(aud_head[3:0])], $sampled(o_aud_rd_data));
            errors++;
        end

    // video words come back in frame order
    a_vid_data: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        o_video_rd_valid |-> (o_video_rd_data == unwritten_word(vid_head)))
        else begin
            $display("CHECK FAILED o_video_rd_data expected %h got %h",
                unwritten_word($sampled(vid_head)), $sampled(o_video_rd_data));
            errors++;
        end

    a_vid_inflight: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        o_video_rd_valid |-> (vid_inflight > 0))
        else begin
            $display("video data returned with no video request in flight");
            errors++;
        end

    a_vid_hold: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (i_video_af && !prev_stall) |->
            !(o_mem_stb && !o_mem_we && o_mem_addr >= VIDEO_BASE_ADDR))
        else begin
            $display("new video request issued while almost full");
            errors++;
        end

    // fresh choice with both pending goes to audio
    a_arbitration: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (o_mem_stb && aud_pending && complete_seen && !i_video_af && !prev_stall)
            |-> (!o_mem_we && o_mem_addr == aud_last))
        else begin
            $display("CHECK FAILED o_mem_addr expected %h got %h",
                $sampled(aud_last), $sampled(o_mem_addr));
            errors++;
        end

    a_depth: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        inflight <= TAG_FIFO_DEPTH)
        else begin
            $display("more than %0d requests without acknowledgement", TAG_FIFO_DEPTH);
            errors++;
        end

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk_dram_ctrl);
    endtask

    // ready is stable from one falling edge to the next rising edge
    task automatic send_sample_word(input data_t d, input logic last);
        logic taken;
        i_wr_valid = 1'b1;
        i_wr_data  = d;
        i_wr_last  = last;
        do begin
            taken = o_wr_ready;
            @(negedge clk_dram_ctrl);
        end while (!taken);
        i_wr_valid = 1'b0;
        i_wr_last  = 1'b0;
    endtask

    task automatic send_audio_addr(input addr_t a);
        logic taken;
        i_aud_addr_valid = 1'b1;
        i_aud_addr       = a;
        do begin
            taken = o_aud_addr_ready;
            @(negedge clk_dram_ctrl);
        end while (!taken);
        i_aud_addr_valid = 1'b0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s finished, %0d errors", name, errors - errors_before);
    endtask

    initial begin
        int    e0;
        int    idx;
        int    vid_mark;
        addr_t order [LOAD_WORDS];
        addr_t tmp;
        rst_dram_ctrl    = 1'b1;
        i_wr_valid       = 1'b0;
        i_wr_data        = '0;
        i_wr_last        = 1'b0;
        i_aud_addr_valid = 1'b0;
        i_aud_addr       = '0;
        i_video_af       = 1'b0;
        repeat (16) @(negedge clk_dram_ctrl);
        rst_dram_ctrl = 1'b0;
        after_reset   = 1'b1;
        @(negedge clk_dram_ctrl);
        after_reset = 1'b0;
        report_test("reset", 0);

        e0 = errors;
        for (int i = 0; i < LOAD_WORDS; i++) begin
            for (int w = 0; w < 4; w++) begin
                lcg = lcg_step(lcg);
                load_data[i][w*32 +: 32] = lcg;
            end
            lcg = lcg_step(lcg);
            idle_cycles(lcg[25:24]);
            send_sample_word(load_data[i], i == LOAD_WORDS - 1);
        end
        report_test("sample load", e0);

        e0 = errors;
        while (!complete_seen) idle_cycles(1);
        idle_cycles(4);
        report_test("load completion", e0);

        // shuffled audio addresses with video running alongside
        e0 = errors;
        for (int i = 0; i < LOAD_WORDS; i++) order[i] = addr_t'(i);
        for (int i = LOAD_WORDS - 1; i > 0; i--) begin
            lcg  = lcg_step(lcg);
            idx  = int'(lcg[31:16]) % (i + 1);
            tmp  = order[i];
            order[i]   = order[idx];
            order[idx] = tmp;
        end
        for (int i = 0; i < LOAD_WORDS; i++) begin
            lcg = lcg_step(lcg);
            idle_cycles(lcg[26:24]);
            send_audio_addr(order[i]);
        end
        while (aud_returned < LOAD_WORDS) idle_cycles(1);
        report_test("audio reads", e0);

        e0 = errors;
        while (vid_returned < 24) idle_cycles(1);
        report_test("video reads", e0);

        // almost full hold with audio traffic mixed in
        e0 = errors;
        i_video_af = 1'b1;
        idle_cycles(ACK_LATENCY + 10);
        send_audio_addr(order[0]);
        idle_cycles(30);
        i_video_af = 1'b0;
        vid_mark   = vid_returned;
        while (vid_returned < vid_mark + 16) idle_cycles(1);
        while (inflight != 0) idle_cycles(1);
        idle_cycles(4);
        report_test("arbitration and almost full", e0);

        $display("%0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
